/* awb_params.svh */
`ifndef AWB_PARAMS_SVH
`define AWB_PARAMS_SVH

// Active frame size, 1280x720 works as well
`define AWB_H_ACT 16
`define AWB_V_ACT 8

// Coordinate field widths
`define AWB_X_W ($clog2(`AWB_H_ACT))
`define AWB_Y_W ($clog2(`AWB_V_ACT))

// Holds a full frame of pixels at 255
`define AWB_SUM_W ($clog2(`AWB_H_ACT * `AWB_V_ACT * 255 + 1))

// Unsigned fixed point gain, 256 is unity
`define AWB_GAIN_W 10
`define AWB_GAIN_FRAC 8

// Per pixel mean at or below this counts as dark
`define AWB_DARK_THRESH 4

`endif

/* awb_pkg.sv */
`include "awb_params.svh"

package awb_pkg;

    // One pixel of the stream with its timing flags
    typedef struct packed {
        logic                hsync;
        logic                vsync;
        logic                de;
        logic [7:0]          r;
        logic [7:0]          g;
        logic [7:0]          b;
        logic [`AWB_X_W-1:0] x;
        logic [`AWB_Y_W-1:0] y;
    } awb_pix_t;

    // Frame totals per channel
    typedef struct packed {
        logic [`AWB_SUM_W-1:0] r;
        logic [`AWB_SUM_W-1:0] g;
        logic [`AWB_SUM_W-1:0] b;
    } awb_sums_t;

    // Gains per channel
    typedef struct packed {
        logic [`AWB_GAIN_W-1:0] r;
        logic [`AWB_GAIN_W-1:0] g;
        logic [`AWB_GAIN_W-1:0] b;
    } awb_gains_t;

endpackage : awb_pkg

/* awb_frame_timer.sv */
`timescale 1ns/1ps
`include "awb_params.svh"

module awb_frame_timer
    import awb_pkg::*;
(
    input  logic                  clk,
    input  logic                  rstn,
    input  awb_pix_t              i_pix,
    output logic                  o_frame_start,
    output logic                  o_frame_end,
    output logic [`AWB_SUM_W-1:0] o_pix_count
);

    logic                  vsync_d;
    logic [`AWB_SUM_W-1:0] pix_cnt;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            vsync_d <= 1'b0;
        end else begin
            vsync_d <= i_pix.vsync;
        end
    end

    // Vsync rise opens the frame gap, vsync fall closes it
    assign o_frame_start = i_pix.vsync & ~vsync_d;
    assign o_frame_end   = ~i_pix.vsync & vsync_d;

    // Count of de pixels between two vsync falls
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            pix_cnt     <= '0;
            o_pix_count <= '0;
        end else if (o_frame_end) begin
            pix_cnt     <= '0;
            o_pix_count <= pix_cnt;
        end else if (i_pix.de) begin
            pix_cnt <= pix_cnt + 1'b1;
        end
    end

    // Active pixels stay clear of the vsync edges
    a_no_de_on_edge: assert property (
        @(posedge clk) disable iff (!rstn)
        (o_frame_start || o_frame_end) |-> !i_pix.de
    );

endmodule : awb_frame_timer

/* awb_refresh_fsm.sv */
`timescale 1ns/1ps
`include "awb_params.svh"

module awb_refresh_fsm
    import awb_pkg::*;
(
    input  logic                  clk,
    input  logic                  rstn,
    input  logic                  i_update,
    input  logic                  i_frame_end,
    input  awb_sums_t             i_sums,
    input  logic [`AWB_SUM_W-1:0] i_pix_count,
    output logic                  o_refresh
);

    typedef enum logic {
        CAPTURE,
        HOLD
    } state_t;

    state_t                state;
    logic                  pending;
    logic [`AWB_SUM_W+2:0] dark_lim;
    logic                  frame_dark;

    // Dark when every channel mean is at the threshold or below
    assign dark_lim   = i_pix_count * `AWB_DARK_THRESH;
    assign frame_dark = (i_sums.r <= dark_lim) &&
                        (i_sums.g <= dark_lim) &&
                        (i_sums.b <= dark_lim);

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            pending <= 1'b0;
        end else if (i_frame_end) begin
            pending <= 1'b0;
        end else if (i_update) begin
            pending <= 1'b1;
        end
    end

    // Decision taken once per frame, at the vsync fall
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state <= CAPTURE;
        end else if (i_frame_end) begin
            if (pending || i_update || frame_dark) begin
                state <= CAPTURE;
            end else begin
                state <= HOLD;
            end
        end
    end

    assign o_refresh = (state == CAPTURE);

    // Update request is a single cycle pulse
    a_update_pulse: assert property (
        @(posedge clk) disable iff (!rstn)
        i_update |=> !i_update
    );

endmodule : awb_refresh_fsm

/* awb_channel_stats.sv */
`timescale 1ns/1ps
`include "awb_params.svh"

module awb_channel_stats
    import awb_pkg::*;
(
    input  logic      clk,
    input  logic      rstn,
    input  awb_pix_t  i_pix,
    input  logic      i_frame_start,
    input  logic      i_refresh,
    output awb_sums_t o_sums,
    output logic      o_sums_valid
);

    awb_sums_t           run;
    logic [`AWB_SUM_W:0] nxt_r;
    logic [`AWB_SUM_W:0] nxt_g;
    logic [`AWB_SUM_W:0] nxt_b;

    // One extra bit to catch a carry out
    assign nxt_r = run.r + i_pix.r;
    assign nxt_g = run.g + i_pix.g;
    assign nxt_b = run.b + i_pix.b;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            run          <= '0;
            o_sums       <= '0;
            o_sums_valid <= 1'b0;
        end else begin
            o_sums_valid <= 1'b0;
            if (i_refresh) begin
                if (i_frame_start) begin
                    // Hand over the finished frame and start again
                    o_sums       <= run;
                    o_sums_valid <= 1'b1;
                    run          <= '0;
                end else if (i_pix.de) begin
                    run.r <= nxt_r[`AWB_SUM_W-1:0];
                    run.g <= nxt_g[`AWB_SUM_W-1:0];
                    run.b <= nxt_b[`AWB_SUM_W-1:0];
                end
            end
        end
    end

    // Needs a vsync within every frame's worth of pixels
    a_sum_no_wrap: assert property (
        @(posedge clk) disable iff (!rstn)
        (i_refresh && !i_frame_start && i_pix.de) |->
            !(nxt_r[`AWB_SUM_W] || nxt_g[`AWB_SUM_W] || nxt_b[`AWB_SUM_W])
    );

endmodule : awb_channel_stats

/* awb_gain_calc.sv */
`timescale 1ns/1ps
`include "awb_params.svh"

module awb_gain_calc
    import awb_pkg::*;
(
    input  logic       clk,
    input  logic       rstn,
    input  awb_sums_t  i_sums,
    input  logic       i_sums_valid,
    output awb_gains_t o_gains
);

    localparam logic [`AWB_GAIN_W-1:0] GAIN_UNITY = 1 << `AWB_GAIN_FRAC;
    localparam logic [`AWB_GAIN_W-1:0] GAIN_MAX   = '1;

    logic [`AWB_SUM_W+1:0] total;
    logic [`AWB_SUM_W+1:0] third;
    logic [`AWB_SUM_W-1:0] mean;
    logic                  mean_valid;

    // mean * 256 / sum, clipped to the gain range
    function automatic logic [`AWB_GAIN_W-1:0] chan_gain(
        input logic [`AWB_SUM_W-1:0] avg,
        input logic [`AWB_SUM_W-1:0] sum
    );
        logic [`AWB_SUM_W+`AWB_GAIN_FRAC-1:0] quot;
        if (sum == '0) begin
            return GAIN_UNITY;
        end
        quot = {avg, {`AWB_GAIN_FRAC{1'b0}}} / sum;
        if (quot > GAIN_MAX) begin
            return GAIN_MAX;
        end
        return quot[`AWB_GAIN_W-1:0];
    endfunction

    assign total = i_sums.r + i_sums.g + i_sums.b;
    assign third = total / 3;

    // Stage one, mean of the three channels
    always_ff @(posedge clk) begin
        if (i_sums_valid) begin
            mean <= third[`AWB_SUM_W-1:0];
        end
    end

    // Stage two, per channel quotient
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            mean_valid <= 1'b0;
            o_gains.r  <= GAIN_UNITY;
            o_gains.g  <= GAIN_UNITY;
            o_gains.b  <= GAIN_UNITY;
        end else begin
            mean_valid <= i_sums_valid;
            if (mean_valid) begin
                o_gains.r <= chan_gain(mean, i_sums.r);
                o_gains.g <= chan_gain(mean, i_sums.g);
                o_gains.b <= chan_gain(mean, i_sums.b);
            end
        end
    end

endmodule : awb_gain_calc

/* awb_pixel_gain.sv */
`timescale 1ns/1ps
`include "awb_params.svh"

module awb_pixel_gain
    import awb_pkg::*;
(
    input  logic       clk,
    input  logic       rstn,
    input  awb_pix_t   i_pix,
    input  awb_gains_t i_gains,
    input  logic       i_en,
    output awb_pix_t   o_pix
);

    localparam int PROD_W = 8 + `AWB_GAIN_W;

    awb_pix_t          pix_d;
    logic [PROD_W-1:0] prod_r;
    logic [PROD_W-1:0] prod_g;
    logic [PROD_W-1:0] prod_b;

    // Drop the fraction bits and clamp to 8 bits
    function automatic logic [7:0] sat8(input logic [PROD_W-1:0] prod);
        logic [PROD_W-`AWB_GAIN_FRAC-1:0] scaled;
        scaled = prod[PROD_W-1:`AWB_GAIN_FRAC];
        if (scaled > 8'd255) begin
            return 8'hff;
        end
        return scaled[7:0];
    endfunction

    // Stage one, products
    always_ff @(posedge clk) begin
        prod_r <= i_pix.r * i_gains.r;
        prod_g <= i_pix.g * i_gains.g;
        prod_b <= i_pix.b * i_gains.b;
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            pix_d <= '0;
        end else begin
            pix_d <= i_pix;
        end
    end

    // Stage two, saturate, or pass the delayed original through
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            o_pix <= '0;
        end else begin
            o_pix <= pix_d;
            if (i_en) begin
                o_pix.r <= sat8(prod_r);
                o_pix.g <= sat8(prod_g);
                o_pix.b <= sat8(prod_b);
            end
        end
    end

endmodule : awb_pixel_gain

/* awb_top.sv */
`timescale 1ns/1ps
`include "awb_params.svh"

module awb_top
    import awb_pkg::*;
(
    input  logic     clk,
    input  logic     rstn,
    input  awb_pix_t i_pix,
    input  logic     i_en,
    input  logic     i_update,
    output awb_pix_t o_pix
);

    logic                  frame_start;
    logic                  frame_end;
    logic [`AWB_SUM_W-1:0] pix_count;
    logic                  refresh;
    awb_sums_t             sums;
    logic                  sums_valid;
    awb_gains_t            gains;

    awb_frame_timer timer_inst (
        .clk          (clk        ),
        .rstn         (rstn       ),
        .i_pix        (i_pix      ),
        .o_frame_start(frame_start),
        .o_frame_end  (frame_end  ),
        .o_pix_count  (pix_count  )
    );

    awb_refresh_fsm refresh_inst (
        .clk        (clk      ),
        .rstn       (rstn     ),
        .i_update   (i_update ),
        .i_frame_end(frame_end),
        .i_sums     (sums     ),
        .i_pix_count(pix_count),
        .o_refresh  (refresh  )
    );

    awb_channel_stats stats_inst (
        .clk          (clk        ),
        .rstn         (rstn       ),
        .i_pix        (i_pix      ),
        .i_frame_start(frame_start),
        .i_refresh    (refresh    ),
        .o_sums       (sums       ),
        .o_sums_valid (sums_valid )
    );

    awb_gain_calc gain_inst (
        .clk         (clk       ),
        .rstn        (rstn      ),
        .i_sums      (sums      ),
        .i_sums_valid(sums_valid),
        .o_gains     (gains     )
    );

    awb_pixel_gain pixel_inst (
        .clk    (clk  ),
        .rstn   (rstn ),
        .i_pix  (i_pix),
        .i_gains(gains),
        .i_en   (i_en ),
        .o_pix  (o_pix)
    );

endmodule : awb_top

/* awb_tb.sv */
`timescale 1ns/1ps
`include "awb_params.svh"

module awb_tb
    import awb_pkg::*;
();

    // Vsync, two porches and the active lines, each line followed by 4 cycles of hsync
    localparam int FRAME_CYC  = 12 + `AWB_V_ACT * (`AWB_H_ACT + 4);
    localparam int NUM_FRAMES = 10;
    localparam int TIMEOUT_NS = (NUM_FRAMES * FRAME_CYC + 100) * 20;

    logic           clk;
    logic           rstn;
    logic           i_en;
    logic           i_update;
    awb_pix_t       i_pix;
    awb_pix_t       o_pix;
    awb_pix_t       exp_pix;
    // Delay lines that line up with o_pix
    awb_pix_t [1:0] pix_d;
    awb_pix_t [1:0] exp_d;
    logic           en_d;

    // Model of refresh, captured sums and gains
    int m_acc[3];
    int m_sums[3];
    int m_gain[3] = '{256, 256, 256};
    int m_count   = 0;
    int m_de      = 0;
    bit m_refresh = 1'b1;
    bit m_pending = 1'b0;

    int seed     = 2;
    int errors   = 0;
    int err_mark = 0;
    int tests    = 0;
    int failed   = 0;

    awb_top awb_top_inst (
        .clk     (clk     ),
        .rstn    (rstn    ),
        .i_pix   (i_pix   ),
        .i_en    (i_en    ),
        .i_update(i_update),
        .o_pix   (o_pix   )
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        pix_d <= {pix_d[0], i_pix};
        exp_d <= {exp_d[0], exp_pix};
        en_d  <= i_en;
    end

    task automatic report_mismatch(input string name, input awb_pix_t exp, input awb_pix_t got);
        errors++;
        $display("ERR %0t %s expected %h got %h", $time, name, exp, got);
    endtask

    a_out_model: assert property (@(posedge clk) disable iff (!rstn) o_pix == exp_d[1])
        else report_mismatch("o_pix", $sampled(exp_d[1]), $sampled(o_pix));

    a_out_bypass: assert property (@(posedge clk) disable iff (!rstn)
        !en_d |-> o_pix == pix_d[1])
        else report_mismatch("o_pix bypass", $sampled(pix_d[1]), $sampled(o_pix));

    // Drives one pixel and its expected output
    task automatic drive_pix(input awb_pix_t p, input logic en);
        awb_pix_t    e;
        logic [23:0] col;
        int          v;
        col = {p.r, p.g, p.b};
        for (int c = 0; c < 3; c++) begin
            v = (col[16 - 8 * c +: 8] * m_gain[c]) >> 8;
            if (en) begin
                col[16 - 8 * c +: 8] = (v > 255) ? 8'hff : 8'(v);
            end
        end
        e = p;
        {e.r, e.g, e.b} = col;
        @(posedge clk);
        i_pix   <= p;
        exp_pix <= e;
    endtask

    task automatic blank(input int n, input logic hs, input logic vs);
        awb_pix_t p;
        p       = '0;
        p.hsync = hs;
        p.vsync = vs;
        repeat (n) drive_pix(p, 1'b0);
    endtask

    // A fixed color of zero asks for random pixels
    task automatic run_frame(input logic en, input logic [23:0] fix, input bit upd);
        awb_pix_t    p;
        logic [31:0] rnd;
        bit          dark;
        int          mean;
        int          q;
        i_en <= en;
        if (m_refresh) begin
            m_sums = m_acc;
            m_acc  = '{0, 0, 0};
            mean   = (m_sums[0] + m_sums[1] + m_sums[2]) / 3;
            for (int c = 0; c < 3; c++) begin
                q         = (m_sums[c] == 0) ? 256 : mean * 256 / m_sums[c];
                m_gain[c] = (q > 1023) ? 1023 : q;
            end
        end
        blank(4, 1'b0, 1'b1);
        // Vsync fall decides capture of this frame
        dark = 1'b1;
        for (int c = 0; c < 3; c++) begin
            dark &= (m_sums[c] <= m_count * `AWB_DARK_THRESH);
        end
        m_refresh = m_pending || dark;
        m_pending = 1'b0;
        m_count   = m_de;
        m_de      = 0;
        blank(4, 1'b0, 1'b0);
        for (int y = 0; y < `AWB_V_ACT; y++) begin
            for (int x = 0; x < `AWB_H_ACT; x++) begin
                rnd             = $random(seed);
                p               = '0;
                p.de            = 1'b1;
                {p.r, p.g, p.b} = (fix == '0) ? rnd[23:0] : fix;
                p.x             = x[`AWB_X_W-1:0];
                p.y             = y[`AWB_Y_W-1:0];
                drive_pix(p, en);
                i_update <= upd && (x == 0) && (y == `AWB_V_ACT / 2);
                if (m_refresh) begin
                    m_acc[0] += p.r;
                    m_acc[1] += p.g;
                    m_acc[2] += p.b;
                end
                m_de++;
            end
            blank(4, 1'b1, 1'b0);
        end
        blank(4, 1'b0, 1'b0);
        m_pending |= upd;
    endtask

    task automatic finish_test(input string name);
        tests++;
        if (errors == err_mark) begin
            $display("Test %0d, %s: passed", tests, name);
        end else begin
            failed++;
            $display("Test %0d, %s: failed with %0d errors", tests, name, errors - err_mark);
        end
        err_mark = errors;
    endtask

    initial begin
        rstn     = 1'b0;
        i_en     = 1'b0;
        i_update = 1'b0;
        i_pix    = '0;
        exp_pix  = '0;
        repeat (5) @(posedge clk);
        rstn <= 1'b1;
        run_frame(1'b1, 24'h0, 1'b0);
        finish_test("unity gains in first frame");
        run_frame(1'b0, 24'h0, 1'b1);
        finish_test("bypass with enable low");
        run_frame(1'b1, {8'd100, 8'd50, 8'd150}, 1'b0);
        run_frame(1'b1, 24'h0, 1'b0);
        finish_test("gains from constant frame");
        run_frame(1'b1, 24'h0, 1'b1);
        finish_test("gains frozen while holding");
        run_frame(1'b1, {8'd60, 8'd120, 8'd90}, 1'b0);
        run_frame(1'b1, 24'h0, 1'b1);
        finish_test("update pulse recaptures");
        run_frame(1'b1, {8'd2, 8'd2, 8'd2}, 1'b0);
        run_frame(1'b1, {8'd30, 8'd200, 8'd80}, 1'b0);
        run_frame(1'b1, 24'h0, 1'b0);
        finish_test("dark frame keeps capturing");
        $display("Summary: %0d tests, %0d failed, %0d check errors", tests, failed, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

    initial begin
        #TIMEOUT_NS;
        $display("Timeout: the frames did not finish within %0d ns", TIMEOUT_NS);
        $display("TEST FAIL");
        $finish;
    end

endmodule : awb_tb

/* awb.f */
+incdir+.
awb_pkg.sv
awb_frame_timer.sv
awb_refresh_fsm.sv
awb_channel_stats.sv
awb_gain_calc.sv
awb_pixel_gain.sv
awb_top.sv
awb_tb.sv
